//--- source/risk_gateway_macros.svh
//////////////////////////////
// widths and depths shared by the risk gateway RTL
// include wherever a field width or memory size is needed
//////////////////////////////
`ifndef RISK_GATEWAY_MACROS_SVH
`define RISK_GATEWAY_MACROS_SVH

`define RG_QTY_W 16 // order quantity bits
`define RG_PRICE_W 16 // order price bits

// one trade word carries either an order or a limit pair
`define RG_WORD_W (`RG_QTY_W + `RG_PRICE_W)

`define RG_DEPTH 16 // order memory entries
`define RG_WRITE_CYCLES 3 // slow write path latency, also used for limit loads

`endif

//--- source/risk_gateway_pkg.sv
//////////////////////////////
// types for the risk gateway: order, limit pair,
// the shared trade word and the FSM state encoding
//////////////////////////////
`default_nettype none
`include "risk_gateway_macros.svh"

package risk_gateway_pkg;

  typedef struct packed {
    logic [`RG_QTY_W-1:0]   qty;
    logic [`RG_PRICE_W-1:0] price;
  } order_t;

  typedef struct packed {
    logic [`RG_QTY_W-1:0]   max_qty;
    logic [`RG_PRICE_W-1:0] max_price;
  } limit_t;

  // the data input is an order under new_order and a limit under new_max
  typedef union packed {
    order_t order;
    limit_t limit;
  } trade_word_u;

  // one-hot FSM states
  typedef enum logic [4:0] {
    IDLE              = 5'b00001,
    RISKCHECK         = 5'b00010,
    SENDORDER         = 5'b00100,
    NEWMAX            = 5'b01000,
    RISKCHK_SENDORDER = 5'b10000 // sending one order, the next one waiting
  } fsm_state_e;

endpackage

`default_nettype wire

//--- source/gateway_ctrl_if.sv
//////////////////////////////
// control strobes between the gateway FSM, the
// risk checker, the write timer and the order store
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

interface gateway_ctrl_if;
  logic check_risk; // FSM wants a verdict on pending_order
  logic send_order; // order write in progress
  logic update_max; // limit write in progress
  logic risk_ok;    // 1 = pass
  logic memwr;      // one-cycle end of the slow write

  modport fsm (output check_risk, send_order, update_max, input risk_ok, memwr);
  modport risk (input check_risk, update_max, memwr, output risk_ok);
  modport timer (input send_order, update_max, output memwr);

  // update_max only watched here by an assertion
  modport store (input send_order, update_max, memwr);
endinterface

`default_nettype wire

//--- source/upstream_processor.sv
//////////////////////////////
// one-hot order-flow FSM with max-over-order arbiter
// and a single pending-order slot
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "risk_gateway_macros.svh"

module upstream_processor
  import risk_gateway_pkg::*;
(
  input  logic           clk,
  input  logic           HRESETn,
  input  logic           new_order,
  input  logic           new_max,
  input  trade_word_u    trade_word,
  gateway_ctrl_if.fsm    ctrl,
  output order_t         pending_order, // order under check or being written
  output limit_t         pending_limit,
  output logic           busy
);

  fsm_state_e state;
  logic       order_pend; // slot holds an order not yet started
  logic       max_pend;   // a limit waits for the write path
  order_t     slot_order;
  logic       accept_order;
  logic       leave;      // current job is done this cycle
  logic       load_slot;
  logic       take_max;
  fsm_state_e leave_to;

  // a same-cycle limit or a full slot drops the order
  assign accept_order = new_order && !new_max && !order_pend;

  // leave from idle, after a failed check or at the end of a slow write
  assign leave = (state == IDLE) || ((state == RISKCHECK) && !ctrl.risk_ok) || ctrl.memwr;
  assign take_max  = leave && max_pend;               // limits go first
  assign load_slot = leave && order_pend && !max_pend;
  assign leave_to  = max_pend ? NEWMAX : (order_pend ? RISKCHECK : IDLE);

  always_ff @(posedge clk) begin
    if (!HRESETn) begin
      state      <= IDLE;
      order_pend <= 1'b0;
      max_pend   <= 1'b0;
    end else begin
      if (leave) begin
        state <= leave_to; // shortcuts skip the pass through idle
      end else if (state == RISKCHECK) begin
        // check passed so the order moves on to the write path
        state <= order_pend ? RISKCHK_SENDORDER : SENDORDER;
      end else if ((state == SENDORDER) && order_pend) begin
        state <= RISKCHK_SENDORDER; // next order arrived mid-write
      end

      if (load_slot) order_pend <= 1'b0;
      if (accept_order) order_pend <= 1'b1;
      if (take_max) max_pend <= 1'b0;
      if (new_max) max_pend <= 1'b1; // a fresh limit always wins
    end
  end

  // order and limit payload follows the strobes
  always_ff @(posedge clk) begin
    if (new_max) pending_limit <= trade_word.limit; // later limit overwrites
    if (accept_order) slot_order <= trade_word.order;
    if (load_slot) pending_order <= slot_order;
  end

  assign ctrl.check_risk = (state == RISKCHECK) || (state == RISKCHK_SENDORDER);
  assign ctrl.send_order = (state == SENDORDER) || (state == RISKCHK_SENDORDER);
  assign ctrl.update_max = (state == NEWMAX);

  assign busy = (state != IDLE) || order_pend || max_pend;

  a_state_onehot: assert property (@(posedge clk) disable iff (!HRESETn) $onehot(state));

  // timer and store rely on only one write request at a time
  a_one_write: assert property (@(posedge clk) disable iff (!HRESETn)
    !(ctrl.send_order && ctrl.update_max));

endmodule

`default_nettype wire

//--- source/risk_checker.sv
//////////////////////////////
// limit register and the pass/fail compare
// of the pending order, risk_ok = 1 is a pass
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "risk_gateway_macros.svh"

module risk_checker
  import risk_gateway_pkg::*;
(
  input  logic        clk,
  input  logic        HRESETn,
  gateway_ctrl_if.risk ctrl,
  input  order_t      pending_order,
  input  limit_t      pending_limit
);

  limit_t limit_q; // active limit pair
  logic   qty_ok;
  logic   price_ok;

  // all ones out of reset, every order passes until a limit is written
  always_ff @(posedge clk) begin
    if (!HRESETn) begin
      limit_q <= '1;
    end else if (ctrl.memwr && ctrl.update_max) begin
      limit_q <= pending_limit; // end of the slow limit write
    end
  end

  // inclusive bounds
  assign qty_ok   = (pending_order.qty <= limit_q.max_qty);
  assign price_ok = (pending_order.price <= limit_q.max_price);

  // verdict only meaningful while the FSM asks for it
  assign ctrl.risk_ok = ctrl.check_risk && qty_ok && price_ok;

endmodule

`default_nettype wire

//--- source/mem_write_timer.sv
//////////////////////////////
// models the slow write path, counts cycles in a
// write state and pulses memwr at the end
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "risk_gateway_macros.svh"

module mem_write_timer (
  input  logic          clk,
  input  logic          HRESETn,
  gateway_ctrl_if.timer ctrl
);

  localparam int CNT_W = $clog2(`RG_WRITE_CYCLES + 1);

  logic [CNT_W-1:0] cnt;
  logic             req;

  assign req = ctrl.send_order || ctrl.update_max;

  // pulse in the last cycle of the write
  assign ctrl.memwr = req && (cnt == CNT_W'(`RG_WRITE_CYCLES - 1));

  always_ff @(posedge clk) begin
    if (!HRESETn) begin
      cnt <= '0;
    end else if (!req || ctrl.memwr) begin
      cnt <= '0; // back-to-back writes restart here
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // each write ends once, even when the next one follows directly
  a_memwr_single: assert property (@(posedge clk) disable iff (!HRESETn)
    ctrl.memwr |=> !ctrl.memwr);

endmodule

`default_nettype wire

//--- source/order_store.sv
//////////////////////////////
// order memory, written at the end of each send,
// with a saturating count and a read port
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "risk_gateway_macros.svh"

module order_store
  import risk_gateway_pkg::*;
(
  input  logic                              clk,
  input  logic                              HRESETn,
  gateway_ctrl_if.store                     ctrl,
  input  order_t                            pending_order,
  input  logic [$clog2(`RG_DEPTH)-1:0]      rd_addr,
  output order_t                            rd_data,
  output logic [$clog2(`RG_DEPTH+1)-1:0]    order_count,
  output logic                              sent_valid,
  output order_t                            sent_order
);

  localparam int ADDR_W = $clog2(`RG_DEPTH);

  order_t            mem [`RG_DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic              wr;

  assign wr = ctrl.memwr && ctrl.send_order;

  always_ff @(posedge clk) begin
    if (!HRESETn) begin
      wr_ptr      <= '0;
      order_count <= '0;
      sent_valid  <= 1'b0;
    end else begin
      sent_valid <= wr; // one pulse per stored order
      if (wr) begin
        wr_ptr <= (wr_ptr == ADDR_W'(`RG_DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // oldest overwritten
        if (order_count != ($bits(order_count))'(`RG_DEPTH)) order_count <= order_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr] <= pending_order;
      sent_order  <= pending_order;
    end
  end

  assign rd_data = mem[rd_addr];

  // limit loads share memwr, the FSM must keep the two writes apart
  a_no_write_on_max: assert property (@(posedge clk) disable iff (!HRESETn)
    !(wr && ctrl.update_max));

endmodule

`default_nettype wire

//--- source/risk_gateway_top.sv
//////////////////////////////
// pre-trade risk gateway, plain ports outside,
// FSM, risk check, write timer and order memory inside
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "risk_gateway_macros.svh"

module risk_gateway_top
  import risk_gateway_pkg::*;
(
  input  logic                           clk,
  input  logic                           HRESETn,
  input  logic                           new_order,
  input  logic                           new_max,
  input  logic [`RG_WORD_W-1:0]          trade_word, // order or limit, by strobe
  input  logic [$clog2(`RG_DEPTH)-1:0]   rd_addr,
  output logic                           busy,
  output logic                           sent_valid,
  output logic [`RG_WORD_W-1:0]          sent_order,
  output logic [$clog2(`RG_DEPTH+1)-1:0] order_count,
  output logic [`RG_WORD_W-1:0]          rd_data
);

  gateway_ctrl_if ctrl_if ();

  trade_word_u word;
  order_t      pending_order;
  limit_t      pending_limit;
  order_t      sent_word;
  order_t      rd_word;

  assign word       = trade_word;
  assign sent_order = sent_word;
  assign rd_data    = rd_word;

  upstream_processor u_fsm (
    .clk(clk), .HRESETn(HRESETn), .new_order(new_order), .new_max(new_max),
    .trade_word(word), .ctrl(ctrl_if.fsm), .pending_order(pending_order),
    .pending_limit(pending_limit), .busy(busy)
  );

  risk_checker u_risk (
    .clk(clk), .HRESETn(HRESETn), .ctrl(ctrl_if.risk),
    .pending_order(pending_order), .pending_limit(pending_limit)
  );

  mem_write_timer u_timer (.clk(clk), .HRESETn(HRESETn), .ctrl(ctrl_if.timer));

  order_store u_store (
    .clk(clk), .HRESETn(HRESETn), .ctrl(ctrl_if.store), .pending_order(pending_order),
    .rd_addr(rd_addr), .rd_data(rd_word), .order_count(order_count),
    .sent_valid(sent_valid), .sent_order(sent_word)
  );

endmodule

`default_nettype wire

//--- tests/risk_gateway_checker.sv
//////////////////////////////
// scoreboard for the risk gateway, models the limit
// and the stored orders, compares and reports
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "risk_gateway_macros.svh"

module risk_gateway_checker
  import risk_gateway_pkg::*;
(
  input logic                           clk,
  input logic                           HRESETn,
  input logic                           new_order,
  input logic                           new_max,
  input logic [`RG_WORD_W-1:0]          trade_word,
  input logic                           sent_valid,
  input logic [`RG_WORD_W-1:0]          sent_order,
  input logic [`RG_WORD_W-1:0]          rd_data,
  input logic [$clog2(`RG_DEPTH+1)-1:0] order_count
);

  limit_t model_limit = '1; // no limit yet, everything passes
  order_t exp_q[$];         // orders still due on sent_order
  order_t exp_o;
  order_t model_mem [`RG_DEPTH];
  int     model_wr = 0;
  int     model_total = 0;  // passing orders, not saturated
  string  test_name = "none";
  int     test_errs = 0;
  int     tests_run = 0;
  int     checks = 0;
  int     errors = 0;

  // pass when both fields are within the limit, bounds inclusive
  function automatic bit order_passes(input order_t o, input limit_t l);
    return (o.qty <= l.max_qty) && (o.price <= l.max_price);
  endfunction

  task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errs++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic flag(input string msg);
    errors++;
    test_errs++;
    $display("ERROR in %s: %s", test_name, msg);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (exp_q.size() != 0) flag($sformatf("%0d passing orders never came out", exp_q.size()));
    exp_q.delete();
    tests_run++;
    $display("test %-14s %s (%0d errors)", test_name, (test_errs == 0) ? "ok" : "FAILED",
             test_errs);
  endtask

  task automatic check_count();
    expect_eq("order_count", (model_total > `RG_DEPTH) ? `RG_DEPTH : model_total, order_count);
  endtask

  // entries never written hold nothing to compare
  task automatic check_read(input int addr);
    if (addr < model_total) expect_eq($sformatf("rd_data[%0d]", addr), model_mem[addr], rd_data);
  endtask

  task automatic report();
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
  endtask

  always @(posedge clk) begin
    if (HRESETn) begin
      if (sent_valid) begin
        if (exp_q.size() == 0) begin
          flag($sformatf("order %h sent but none was expected", sent_order));
        end else begin
          exp_o = exp_q.pop_front();
          expect_eq("sent_order", exp_o, sent_order);
        end
      end
      if (new_max) begin
        model_limit = trade_word; // a same-cycle order is dropped
      end else if (new_order && order_passes(trade_word, model_limit)) begin
        exp_q.push_back(trade_word);
        model_mem[model_wr] = trade_word; // memory fills in send order
        model_wr = (model_wr + 1) % `RG_DEPTH;
        model_total++;
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_risk_gateway.sv
//////////////////////////////
// testbench for the risk gateway that drives orders
// and limits while the checker module compares
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "risk_gateway_macros.svh"

module tb_risk_gateway;

  localparam int N_ORDERS = 53; // 6 + 40 + 4 + 2 + 1 issued below
  localparam int TIMEOUT = N_ORDERS * 20 + 200;

  logic                           clk = 1'b0;
  logic                           HRESETn;
  logic                           new_order;
  logic                           new_max;
  logic [`RG_WORD_W-1:0]          trade_word;
  logic [$clog2(`RG_DEPTH)-1:0]   rd_addr;
  logic                           busy;
  logic                           sent_valid;
  logic [`RG_WORD_W-1:0]          sent_order;
  logic [$clog2(`RG_DEPTH+1)-1:0] order_count;
  logic [`RG_WORD_W-1:0]          rd_data;
  int                             cycles = 0;
  int                             t0;
  int                             seed_dummy;
  logic [31:0]                    rnd;

  risk_gateway_top dut_i (.*);
  risk_gateway_checker chk_i (.*);

  always #20 clk = ~clk; // 40 ns period

  // run limit scaled by the number of orders
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT) begin
      $display("timeout after %0d cycles, the gateway never finished", TIMEOUT);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic step(); // inputs change 5 ns after the edge
    @(posedge clk);
    #5;
  endtask

  task automatic issue_order(input logic [`RG_QTY_W-1:0] q, input logic [`RG_PRICE_W-1:0] p);
    new_order  = 1'b1;
    trade_word = {q, p};
    step();
    new_order = 1'b0;
  endtask

  task automatic wait_idle();
    while (busy) step();
    repeat (2) step(); // let the checker see the last sent_valid
  endtask

  initial begin
    HRESETn    = 1'b0;
    new_order  = 1'b0;
    new_max    = 1'b0;
    trade_word = '0;
    rd_addr    = '0;
    seed_dummy = $urandom(32'h71593606);
    repeat (2) @(posedge clk);
    #5 HRESETn = 1'b1;
    step();

    chk_i.begin_test("reset");
    chk_i.expect_eq("busy", 0, busy);
    chk_i.expect_eq("sent_valid", 0, sent_valid);
    chk_i.expect_eq("order_count", 0, order_count);
    for (int i = 0; i < 6; i++) begin
      issue_order(16'hFF00 + i, 16'hFFF0 + i); // big values pass the all-ones limit
      wait_idle();
    end
    chk_i.end_test();

    chk_i.begin_test("limit_filter");
    new_max    = 1'b1;
    trade_word = {16'hC000, 16'hC000};
    step();
    new_max = 1'b0;
    wait_idle();
    repeat (40) begin
      rnd = $urandom;
      issue_order(rnd[31:16], rnd[15:0]);
      wait_idle();
    end
    chk_i.check_count();
    chk_i.end_test();

    chk_i.begin_test("arbiter");
    new_order  = 1'b1; // same word is the order and the new limit
    new_max    = 1'b1;
    trade_word = {16'd100, 16'd100};
    step();
    new_order = 1'b0;
    new_max   = 1'b0;
    wait_idle();
    issue_order(16'd200, 16'd50); // fine under the old limit only
    wait_idle();
    issue_order(16'd100, 16'd100);
    wait_idle();
    issue_order(16'd100, 16'd101);
    wait_idle();
    chk_i.check_count();
    chk_i.end_test();

    chk_i.begin_test("pending_slot");
    issue_order(16'd10, 16'd20);
    step();
    chk_i.expect_eq("busy at second order", 1, busy);
    issue_order(16'd30, 16'd40); // lands in the slot
    wait_idle();
    chk_i.end_test();

    chk_i.begin_test("latency");
    issue_order(16'd50, 16'd60);
    t0 = cycles; // edge that sampled new_order
    while (!sent_valid) step();
    chk_i.expect_eq("cycles to sent_valid", `RG_WRITE_CYCLES + 2, cycles - t0);
    wait_idle();
    chk_i.end_test();

    chk_i.begin_test("readback");
    // more passing orders than entries were sent by now
    chk_i.expect_eq("order_count saturated", `RG_DEPTH, order_count);
    for (int a = 0; a < `RG_DEPTH; a++) begin
      rd_addr = a;
      step();
      chk_i.check_read(a);
    end
    chk_i.end_test();

    chk_i.report();
    if (chk_i.errors == 0) $display("All checks passed");
    else $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+source
source/risk_gateway_pkg.sv
source/gateway_ctrl_if.sv
source/upstream_processor.sv
source/risk_checker.sv
source/mem_write_timer.sv
source/order_store.sv
source/risk_gateway_top.sv
tests/risk_gateway_checker.sv
tests/tb_risk_gateway.sv

//--- Bender.yml
package:
  name: risk_gateway

export_include_dirs:
  - source

sources:
  - files:
      - source/risk_gateway_pkg.sv
      - source/gateway_ctrl_if.sv
      - source/upstream_processor.sv
      - source/risk_checker.sv
      - source/mem_write_timer.sv
      - source/order_store.sv
      - source/risk_gateway_top.sv
  - target: test
    files:
      - tests/risk_gateway_checker.sv
      - tests/tb_risk_gateway.sv
